// ==== vlog.f ====
src/spi_cmd_pkg.sv
src/wb_arbiter.sv
src/spi_cmd_engine.sv
src/spi_shifter.sv
src/spi_cmd_top.sv
dv/spi_dev_model.sv
dv/tb_spi_cmd_top.sv

// ==== Makefile ====
# Verilator simulation of the SPI command controller

VERILATOR ?= verilator
TOP       ?= tb_spi_cmd_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_spi_cmd_top.sv ====
`default_nettype none

module tb_spi_cmd_top;
  import spi_cmd_pkg::*;

  localparam int CLK_DIV   = CLK_DIV_DEF;
  localparam int READ_GAP  = READ_GAP_DEF;
  localparam int N_RAND    = 30;  // Per port
  localparam int N_TXN     = 2 + 2 * N_RAND;
  localparam int CYC_LIMIT = N_TXN * (2 * CLK_DIV * 20 + READ_GAP + 20);

  logic              clk;
  logic              rst_n;
  logic              a_cyc, a_stb, a_we, a_ack;
  logic [ADDR_W-1:0] a_adr;
  logic [DATA_W-1:0] a_dat_w, a_dat_r;
  logic              b_cyc, b_stb, b_we, b_ack;
  logic [ADDR_W-1:0] b_adr;
  logic [DATA_W-1:0] b_dat_w, b_dat_r;
  logic              miso, cs_n, sclk, mosi;
  logic [CMD_W-1:0]  dev_last_word, dev_prev_word;
  logic [3:0]        dev_last_bits, dev_prev_bits;
  int                dev_last_gap;

  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  logic [15:0]       lfsr_state;
  logic              t_we   [2][N_RAND];
  logic [ADDR_W-1:0] t_adr  [2][N_RAND];
  logic [DATA_W-1:0] t_dat  [2][N_RAND];
  int                t_wait [2][N_RAND];
  int                req_cnt [2];
  int                ack_cnt [2];
  int                err_cnt;
  int                cyc_cnt;
  int                last_port;
  logic              other_waited;
  logic              a_req_q;
  logic              b_req_q;

  spi_cmd_top #(
    .CLK_DIV  (CLK_DIV),
    .READ_GAP (READ_GAP)
  ) dut (
    .clk (clk), .rst_n (rst_n),
    .a_cyc (a_cyc), .a_stb (a_stb), .a_we (a_we), .a_adr (a_adr),
    .a_dat_w (a_dat_w), .a_dat_r (a_dat_r), .a_ack (a_ack),
    .b_cyc (b_cyc), .b_stb (b_stb), .b_we (b_we), .b_adr (b_adr),
    .b_dat_w (b_dat_w), .b_dat_r (b_dat_r), .b_ack (b_ack),
    .miso (miso), .cs_n (cs_n), .sclk (sclk), .mosi (mosi)
  );

  spi_dev_model dev (
    .clk (clk), .cs_n (cs_n), .sclk (sclk), .mosi (mosi), .miso (miso),
    .last_word (dev_last_word), .last_bits (dev_last_bits),
    .prev_word (dev_prev_word), .prev_bits (dev_prev_bits),
    .last_gap (dev_last_gap)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ####################################################################
  // Stimulus source and reference model
  // ####################################################################

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  task automatic build_stimulus();
    logic [15:0] v;
    for (int i = 0; i < N_RAND; i++)
    begin
      for (int p = 0; p < 2; p++)
      begin
        take_bits(1, v);
        t_we[p][i] = v[0];
        take_bits(ADDR_W, v);
        t_adr[p][i] = v[ADDR_W-1:0];
        take_bits(DATA_W, v);
        t_dat[p][i] = v[DATA_W-1:0];
        take_bits(2, v);
        t_wait[p][i] = (i == 0) ? 0 : int'(v[1:0]);  // Both ports open together
      end
    end
  endtask

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] adr);
    return ref_mem[adr];
  endfunction

  // ####################################################################
  // Port drivers
  // ####################################################################

  task automatic run_txn(input int p, input logic we, input logic [ADDR_W-1:0] adr,
                         input logic [DATA_W-1:0] dat);
    @(negedge clk);
    if (p == 0)
    begin
      a_we    = we;
      a_adr   = adr;
      a_dat_w = dat;
      a_cyc   = 1'b1;
      a_stb   = 1'b1;
    end
    else
    begin
      b_we    = we;
      b_adr   = adr;
      b_dat_w = dat;
      b_cyc   = 1'b1;
      b_stb   = 1'b1;
    end
    req_cnt[p]++;
    wait (ack_cnt[p] == req_cnt[p]);  // Set by the compare process
    if (p == 0)
    begin
      a_cyc = 1'b0;
      a_stb = 1'b0;
    end
    else
    begin
      b_cyc = 1'b0;
      b_stb = 1'b0;
    end
  endtask

  task automatic run_port(input int p);
    for (int i = 0; i < N_RAND; i++)
    begin
      repeat (t_wait[p][i]) @(negedge clk);
      run_txn(p, t_we[p][i], t_adr[p][i], t_dat[p][i]);
    end
  endtask

  // ####################################################################
  // Compare
  // ####################################################################

  task automatic check_ack(input int p, input logic ack, input logic pending, input logic we,
                           input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat_w,
                           input logic [DATA_W-1:0] dat_r, input logic other_req);
    logic [CMD_W-1:0]  exp_word;
    logic [DATA_W-1:0] exp_dat;
    if (!ack)
      return;
    assert (pending) else
    begin
      $display("Port %0d acknowledged without a pending request", p);
      err_cnt++;
    end
    assert (!(p == last_port && other_waited)) else
    begin
      $display("Port %0d served twice while the other port waited", p);
      err_cnt++;
    end
    last_port    = p;
    other_waited = other_req;
    if (we)
    begin
      exp_word = {OP_WRITE, adr, dat_w};
      assert (dev_last_bits == 4'(CMD_W) && dev_last_word == exp_word) else
      begin
        $display("** Error: dev_last_word = %h (dev_last_bits = %h), expected %h (%h)",
                 dev_last_word, dev_last_bits, exp_word, 4'(CMD_W));
        err_cnt++;
      end
      ref_mem[adr] = dat_w;
    end
    else
    begin
      exp_word = CMD_W'({OP_READ, adr});
      assert (dev_prev_bits == 4'(RHEAD_W) && dev_prev_word == exp_word) else
      begin
        $display("** Error: dev_prev_word = %h (dev_prev_bits = %h), expected %h (%h)",
                 dev_prev_word, dev_prev_bits, exp_word, 4'(RHEAD_W));
        err_cnt++;
      end
      assert (dev_last_bits == 4'(DATA_W)) else
      begin
        $display("** Error: dev_last_bits = %h, expected %h", dev_last_bits, 4'(DATA_W));
        err_cnt++;
      end
      assert (dev_last_gap >= READ_GAP) else
      begin
        $display("CS high for only %0d cycles between read frames", dev_last_gap);
        err_cnt++;
      end
      exp_dat = expected_read(adr);
      assert (dat_r == exp_dat) else
      begin
        $display("** Error: %s_dat_r = %h, expected %h", (p == 0) ? "a" : "b", dat_r, exp_dat);
        err_cnt++;
      end
    end
    ack_cnt[p]++;
  endtask

  always @(posedge clk)
  begin
    a_req_q <= a_cyc && a_stb;  // Requests as seen at the clock edge
    b_req_q <= b_cyc && b_stb;
  end

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      assert (!(a_ack && b_ack)) else
      begin
        $display("Both ports acknowledged in the same cycle");
        err_cnt++;
      end
      check_ack(0, a_ack, a_req_q, a_we, a_adr, a_dat_w, a_dat_r, b_req_q);
      check_ack(1, b_ack, b_req_q, b_we, b_adr, b_dat_w, b_dat_r, a_req_q);
    end
  end

  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt >= CYC_LIMIT)
    begin
      $display("Timeout after %0d cycles, a transaction never completed", cyc_cnt);
      $display("Errors: %0d", err_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // ####################################################################
  // Main sequence
  // ####################################################################

  initial
  begin
    rst_n        = 1'b0;
    a_cyc        = 1'b0;
    a_stb        = 1'b0;
    a_we         = 1'b0;
    a_adr        = '0;
    a_dat_w      = '0;
    b_cyc        = 1'b0;
    b_stb        = 1'b0;
    b_we         = 1'b0;
    b_adr        = '0;
    b_dat_w      = '0;
    a_req_q      = 1'b0;
    b_req_q      = 1'b0;
    err_cnt      = 0;
    cyc_cnt      = 0;
    last_port    = -1;
    other_waited = 1'b0;
    req_cnt      = '{0, 0};
    ack_cnt      = '{0, 0};
    lfsr_state   = 16'd46;
    for (int i = 0; i < 2**ADDR_W; i++)
      ref_mem[i] = 8'((i * 37) ^ 8'h5a);
    build_stimulus();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (4)
    begin
      @(negedge clk);
      assert (cs_n && !sclk && !mosi && !a_ack && !b_ack) else
      begin
        $display("SPI pins or acks not idle after reset");
        err_cnt++;
      end
    end

    run_txn(0, 1'b1, 3'd5, 8'hc3);  // Write then read back on port a
    run_txn(0, 1'b0, 3'd5, 8'h00);

    fork
      run_port(0);
      run_port(1);
    join
    repeat (4) @(negedge clk);

    for (int p = 0; p < 2; p++)
      assert (req_cnt[p] == ack_cnt[p]) else
      begin
        $display("Port %0d issued %0d requests but saw %0d acks", p, req_cnt[p], ack_cnt[p]);
        err_cnt++;
      end

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/spi_dev_model.sv ====
`default_nettype none

module spi_dev_model
  import spi_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             cs_n,
  input  logic             sclk,
  input  logic             mosi,
  output logic             miso,
  output logic [CMD_W-1:0] last_word,  // Bits of the last frame, LSB aligned
  output logic [3:0]       last_bits,
  output logic [CMD_W-1:0] prev_word,
  output logic [3:0]       prev_bits,
  output int               last_gap    // clk cycles CS was high before last frame
);

  logic [DATA_W-1:0] regs [2**ADDR_W];
  logic [CMD_W-1:0]  sr;
  logic [3:0]        nb;
  logic [DATA_W-1:0] dat_sr;
  logic              cs_q;
  logic              sclk_q;
  int                hi_cnt;
  int                cur_gap;

  assign miso = dat_sr[DATA_W-1];

  initial
  begin
    for (int i = 0; i < 2**ADDR_W; i++)
      regs[i] = 8'((i * 37) ^ 8'h5a);  // Same fill as the testbench reference
    cs_q      = 1'b1;
    sclk_q    = 1'b0;
    hi_cnt    = 0;
    cur_gap   = 0;
    sr        = '0;
    nb        = '0;
    dat_sr    = '0;
    last_word = '0;
    last_bits = '0;
    prev_word = '0;
    prev_bits = '0;
    last_gap  = 0;
  end

  always @(posedge clk)
  begin
    cs_q   <= cs_n;
    sclk_q <= sclk;
    if (cs_n)
      hi_cnt <= hi_cnt + 1;
    else
      hi_cnt <= 0;
    if (cs_q && !cs_n)
    begin
      cur_gap <= hi_cnt;  // Frame start
      sr      <= '0;
      nb      <= '0;
      dat_sr  <= (last_bits == 4'(RHEAD_W)) ? regs[last_word[ADDR_W-1:0]] : '0;
    end
    if (!cs_n && sclk && !sclk_q)
    begin
      sr <= {sr[CMD_W-2:0], mosi};  // Rising edge sample
      nb <= nb + 4'd1;
    end
    if (!cs_n && !sclk && sclk_q)
      dat_sr <= {dat_sr[DATA_W-2:0], 1'b0};  // Next bit after falling edge
    if (cs_n && !cs_q)
    begin
      prev_word <= last_word;
      prev_bits <= last_bits;
      last_word <= sr;
      last_bits <= nb;
      last_gap  <= cur_gap;
      if (nb == 4'(CMD_W) && cmd_op_e'(sr[CMD_W-1]) == OP_WRITE)
        regs[sr[CMD_W-2:DATA_W]] <= sr[DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/spi_cmd_top.sv ====
`default_nettype none

module spi_cmd_top
  import spi_cmd_pkg::*;
#(
  parameter int CLK_DIV  = CLK_DIV_DEF,
  parameter int READ_GAP = READ_GAP_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  // Wishbone port a
  input  logic              a_cyc,
  input  logic              a_stb,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_adr,
  input  logic [DATA_W-1:0] a_dat_w,
  output logic [DATA_W-1:0] a_dat_r,
  output logic              a_ack,
  // Wishbone port b
  input  logic              b_cyc,
  input  logic              b_stb,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_adr,
  input  logic [DATA_W-1:0] b_dat_w,
  output logic [DATA_W-1:0] b_dat_r,
  output logic              b_ack,
  // SPI pins
  input  logic              miso,
  output logic              cs_n,
  output logic              sclk,
  output logic              mosi
);

  logic              req;
  logic              req_we;
  logic [ADDR_W-1:0] req_adr;
  logic [DATA_W-1:0] req_dat;
  logic              done;
  logic [DATA_W-1:0] rd_data;
  logic              start;
  logic [3:0]        nbits;
  logic [CMD_W-1:0]  tx_word;
  logic              busy;
  logic              frame_done;
  logic [DATA_W-1:0] rx_byte;

  wb_arbiter u_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .a_cyc   (a_cyc),
    .a_stb   (a_stb),
    .a_we    (a_we),
    .a_adr   (a_adr),
    .a_dat_w (a_dat_w),
    .a_dat_r (a_dat_r),
    .a_ack   (a_ack),
    .b_cyc   (b_cyc),
    .b_stb   (b_stb),
    .b_we    (b_we),
    .b_adr   (b_adr),
    .b_dat_w (b_dat_w),
    .b_dat_r (b_dat_r),
    .b_ack   (b_ack),
    .req     (req),
    .req_we  (req_we),
    .req_adr (req_adr),
    .req_dat (req_dat),
    .done    (done),
    .rd_data (rd_data)
  );

  spi_cmd_engine #(
    .READ_GAP (READ_GAP)
  ) u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_we     (req_we),
    .req_adr    (req_adr),
    .req_dat    (req_dat),
    .done       (done),
    .rd_data    (rd_data),
    .start      (start),
    .nbits      (nbits),
    .tx_word    (tx_word),
    .busy       (busy),
    .frame_done (frame_done),
    .rx_byte    (rx_byte)
  );

  spi_shifter #(
    .CLK_DIV (CLK_DIV)
  ) u_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .nbits      (nbits),
    .tx_word    (tx_word),
    .miso       (miso),
    .busy       (busy),
    .frame_done (frame_done),
    .rx_byte    (rx_byte),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .mosi       (mosi)
  );

endmodule

`default_nettype wire

// ==== src/spi_shifter.sv ====
`default_nettype none

module spi_shifter
  import spi_cmd_pkg::*;
#(
  parameter int CLK_DIV = CLK_DIV_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [3:0]        nbits,
  input  logic [CMD_W-1:0]  tx_word,  // MSB aligned
  input  logic              miso,
  output logic              busy,
  output logic              frame_done,
  output logic [DATA_W-1:0] rx_byte,
  output logic              cs_n,
  output logic              sclk,
  output logic              mosi
);

  localparam int               DIV_W     = $clog2(CLK_DIV);
  localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(CLK_DIV - 1);

  logic [DIV_W-1:0]  half_cnt;
  logic [3:0]        bit_cnt;   // Bits left incl. current
  logic [CMD_W-1:0]  tx_sr;
  logic [DATA_W-1:0] rx_sr;
  logic              half_end;
  logic              rise_evt;
  logic              fall_evt;
  logic              last_bit;

  assign half_end = busy && (half_cnt == HALF_LAST);
  assign rise_evt = half_end && !sclk;
  assign fall_evt = half_end && sclk;
  assign last_bit = (bit_cnt == 4'd1);
  assign rx_byte  = rx_sr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy       <= 1'b0;
      frame_done <= 1'b0;
      cs_n       <= 1'b1;
      sclk       <= 1'b0;
      mosi       <= 1'b0;
      half_cnt   <= '0;
      bit_cnt    <= '0;
    end
    else
    begin
      frame_done <= 1'b0;
      if (start)
      begin
        busy     <= 1'b1;
        cs_n     <= 1'b0;
        sclk     <= 1'b0;
        mosi     <= tx_word[CMD_W-1];  // First bit ahead of first rise
        half_cnt <= '0;
        bit_cnt  <= nbits;
      end
      else if (busy)
      begin
        half_cnt <= half_end ? '0 : half_cnt + 1'b1;
        if (rise_evt)
          sclk <= 1'b1;
        else if (fall_evt)
        begin
          sclk <= 1'b0;
          if (last_bit)
          begin
            busy       <= 1'b0;
            cs_n       <= 1'b1;
            mosi       <= 1'b0;
            frame_done <= 1'b1;
          end
          else
          begin
            bit_cnt <= bit_cnt - 1'b1;
            mosi    <= tx_sr[CMD_W-1];  // Next bit after falling edge
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      tx_sr <= {tx_word[CMD_W-2:0], 1'b0};
    else if (fall_evt)
      tx_sr <= {tx_sr[CMD_W-2:0], 1'b0};
    if (rise_evt)
      rx_sr <= {rx_sr[DATA_W-2:0], miso};  // Sample on rising edge
  end

endmodule

`default_nettype wire

// ==== src/spi_cmd_engine.sv ====
`default_nettype none

module spi_cmd_engine
  import spi_cmd_pkg::*;
#(
  parameter int READ_GAP = READ_GAP_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  // From arbiter
  input  logic              req,
  input  logic              req_we,
  input  logic [ADDR_W-1:0] req_adr,
  input  logic [DATA_W-1:0] req_dat,
  output logic              done,
  output logic [DATA_W-1:0] rd_data,
  // To shifter
  output logic              start,
  output logic [3:0]        nbits,
  output logic [CMD_W-1:0]  tx_word,
  input  logic              busy,
  input  logic              frame_done,
  input  logic [DATA_W-1:0] rx_byte
);

  // Gap counter ends one cycle early since start is combinational
  // and cs_n already rose together with frame_done
  localparam int               GAP_W    = $clog2(READ_GAP);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(READ_GAP - 2);

  eng_state_e       state;
  eng_state_e       state_nxt;
  logic [CMD_W-1:0] cmd_word;
  logic [GAP_W-1:0] gap_cnt;
  cmd_op_e          req_op;
  cmd_op_e          cmd_op;
  logic             gap_end;

  assign req_op  = req_we ? OP_WRITE : OP_READ;
  assign cmd_op  = cmd_op_e'(cmd_word[CMD_W-1]);
  assign gap_end = (state == ST_RGAP) && (gap_cnt == GAP_LAST);

  // ####################################################################
  // State machine
  // ####################################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (req)
          state_nxt = ST_LOAD;
      ST_LOAD:
        if (!busy)
          state_nxt = (cmd_op == OP_WRITE) ? ST_WFRAME : ST_RHEAD;
      ST_WFRAME:
        if (frame_done)
          state_nxt = ST_DONE;
      ST_RHEAD:
        if (frame_done)
          state_nxt = ST_RGAP;
      ST_RGAP:
        if (gap_end)
          state_nxt = ST_RDATA;
      ST_RDATA:
        if (frame_done)
          state_nxt = ST_DONE;
      ST_DONE:
        state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gap_cnt <= '0;
    else if (state == ST_RGAP)
      gap_cnt <= gap_cnt + 1'b1;
    else
      gap_cnt <= '0;
  end

  // ####################################################################
  // Command word and read data
  // ####################################################################

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req)
      cmd_word <= {req_op, req_adr, req_dat};
    if (state == ST_RDATA && frame_done)
      rd_data <= rx_byte;  // Last byte clocked in
  end

  // ####################################################################
  // Shifter control
  // ####################################################################

  assign start = ((state == ST_LOAD) && !busy) || gap_end;
  assign done  = (state == ST_DONE);

  always_comb
  begin
    if (state == ST_RGAP)
    begin
      nbits   = 4'(DATA_W);  // Receive frame, MOSI idle low
      tx_word = '0;
    end
    else if (cmd_op == OP_WRITE)
    begin
      nbits   = 4'(CMD_W);
      tx_word = cmd_word;
    end
    else
    begin
      nbits   = 4'(RHEAD_W);  // Upper bits only
      tx_word = cmd_word;
    end
  end

endmodule

`default_nettype wire

// ==== src/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter
  import spi_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // Port a
  input  logic              a_cyc,
  input  logic              a_stb,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_adr,
  input  logic [DATA_W-1:0] a_dat_w,
  output logic [DATA_W-1:0] a_dat_r,
  output logic              a_ack,
  // Port b
  input  logic              b_cyc,
  input  logic              b_stb,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_adr,
  input  logic [DATA_W-1:0] b_dat_w,
  output logic [DATA_W-1:0] b_dat_r,
  output logic              b_ack,
  // Engine side
  output logic              req,
  output logic              req_we,
  output logic [ADDR_W-1:0] req_adr,
  output logic [DATA_W-1:0] req_dat,
  input  logic              done,
  input  logic [DATA_W-1:0] rd_data
);

  logic busy;    // A transaction is with the engine
  logic gnt;     // 0 = port a, 1 = port b
  logic last_b;  // Port b was served last
  logic a_req;
  logic b_req;
  logic pick_b;

  assign a_req = a_cyc && a_stb;
  assign b_req = b_cyc && b_stb;

  // Round robin when both ask
  assign pick_b = b_req && (!a_req || !last_b);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy   <= 1'b0;
      gnt    <= 1'b0;
      last_b <= 1'b1;  // Port a goes first
    end
    else if (!busy)
    begin
      if (a_req || b_req)
      begin
        busy <= 1'b1;
        gnt  <= pick_b;
      end
    end
    else if (done)
    begin
      busy   <= 1'b0;
      last_b <= gnt;
    end
  end

  // ####################################################################
  // Request mux and response steering
  // ####################################################################

  assign req     = busy;
  assign req_we  = gnt ? b_we    : a_we;
  assign req_adr = gnt ? b_adr   : a_adr;
  assign req_dat = gnt ? b_dat_w : a_dat_w;

  assign a_ack   = done && busy && !gnt;
  assign b_ack   = done && busy && gnt;
  assign a_dat_r = gnt ? '0 : rd_data;
  assign b_dat_r = gnt ? rd_data : '0;

endmodule

`default_nettype wire

// ==== src/spi_cmd_pkg.sv ====
`default_nettype none

package spi_cmd_pkg;

  // ####################################################################
  // Command word layout
  // ####################################################################

  localparam int CMD_W   = 12;  // Opcode, address, data
  localparam int ADDR_W  = 3;
  localparam int DATA_W  = 8;
  localparam int RHEAD_W = 4;   // Opcode plus address only

  // ####################################################################
  // Default timing
  // ####################################################################

  localparam int CLK_DIV_DEF  = 4;   // clk cycles per SCLK half period
  localparam int READ_GAP_DEF = 16;  // CS high between read frames

  // ####################################################################
  // Encodings
  // ####################################################################

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [3:0] {
    ST_IDLE   = 4'd0,
    ST_LOAD   = 4'd1,
    ST_WFRAME = 4'd2,
    ST_RHEAD  = 4'd3,
    ST_RGAP   = 4'd4,
    ST_RDATA  = 4'd5,
    ST_DONE   = 4'd6
  } eng_state_e;

endpackage

`default_nettype wire
